// File: Makefile
# Verilator flow for the debug module testbench

VERILATOR  ?= verilator
TOP        := tb_dm
FLIST      := flist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --timescale 1ns/1ps -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# the simulator exits non-zero when the testbench stops with $fatal
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
hdl/dm_pkg.sv
hdl/dmi_resp_fifo.sv
hdl/dm_ctrl.sv
hdl/hart_slice.sv
hdl/dm_status_merge.sv
hdl/dm_top.sv
testbench/tb_clkgen.sv
testbench/tb_dm.sv

// File: hdl/dm_ctrl.sv
// --------------------
// debug module front end
// DMI decode, dmcontrol register and read data mux
// --------------------
`timescale 1ns/1ps
`default_nettype none

module dm_ctrl (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  wire logic            req_valid_i,
  input  dm_pkg::dmi_req_t     req_i,
  input  wire logic            fifo_full_i,
  output logic                 req_ready_o,
  output logic                 push_o,
  output dm_pkg::dmi_word_t    push_data_o,
  input  dm_pkg::dmi_word_t    dmstatus_i,
  input  dm_pkg::dmi_word_t    haltsum0_i,
  output dm_pkg::hart_ctrl_t   ctrl_o,
  output logic                 dmactive_o,
  output logic                 ndmreset_o
);
  localparam int unsigned HartSelW = $bits(dm_pkg::hartsel_t);

  logic              accept;
  logic              wr_dmcontrol;
  logic              dmactive_q;
  logic              dmactive_d;
  logic              ndmreset_q;
  logic              ndmreset_d;
  logic              haltreq_q;
  logic              haltreq_d;
  dm_pkg::hartsel_t  hartsel_q;
  dm_pkg::hartsel_t  hartsel_d;
  logic              resume_set;
  logic              ack_havereset;
  dm_pkg::dmi_word_t dmcontrol_rd;
  dm_pkg::dmi_word_t rdata;

  // --------------------
  // request acceptance
  // --------------------
  assign req_ready_o  = ~fifo_full_i;
  assign accept       = req_valid_i & req_ready_o;
  assign wr_dmcontrol = accept && (req_i.op == dm_pkg::OpWrite) &&
                        (req_i.addr == dm_pkg::AddrDmControl);

  // --------------------
  // dmcontrol next state
  // --------------------
  always_comb begin : p_next
    dmactive_d    = dmactive_q;
    ndmreset_d    = ndmreset_q;
    haltreq_d     = haltreq_q;
    hartsel_d     = hartsel_q;
    resume_set    = 1'b0;
    ack_havereset = 1'b0;
    if (wr_dmcontrol) begin
      dmactive_d = req_i.data[dm_pkg::DmcDmActive];
      // inactive module only listens to dmactive
      if (dmactive_q) begin
        haltreq_d     = req_i.data[dm_pkg::DmcHaltReq];
        ndmreset_d    = req_i.data[dm_pkg::DmcNdmReset];
        hartsel_d     = req_i.data[dm_pkg::DmcHartSelLo +: HartSelW];
        resume_set    = req_i.data[dm_pkg::DmcResumeReq];
        ack_havereset = req_i.data[dm_pkg::DmcAckHaveReset];
      end
    end
    // soft reset while dmactive is low
    if (!dmactive_d) begin
      haltreq_d     = 1'b0;
      ndmreset_d    = 1'b0;
      hartsel_d     = '0;
      resume_set    = 1'b0;
      ack_havereset = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      dmactive_q <= 1'b0;
      ndmreset_q <= 1'b0;
      haltreq_q  <= 1'b0;
      hartsel_q  <= '0;
    end else begin
      dmactive_q <= dmactive_d;
      ndmreset_q <= ndmreset_d;
      haltreq_q  <= haltreq_d;
      hartsel_q  <= hartsel_d;
    end
  end

  // slices register these, so they see what dmcontrol holds after the edge
  assign ctrl_o.hartsel       = hartsel_d;
  assign ctrl_o.dmactive      = dmactive_d;
  assign ctrl_o.ndmreset      = ndmreset_d;
  assign ctrl_o.haltreq       = haltreq_d;
  assign ctrl_o.resume_set    = resume_set;
  assign ctrl_o.ack_havereset = ack_havereset;

  assign dmactive_o = dmactive_q;
  assign ndmreset_o = ndmreset_q;

  // --------------------
  // read data
  // --------------------
  always_comb begin : p_read
    dmcontrol_rd = '0;
    dmcontrol_rd[dm_pkg::DmcHaltReq]                 = haltreq_q;
    dmcontrol_rd[dm_pkg::DmcHartSelLo +: HartSelW]   = hartsel_q;
    dmcontrol_rd[dm_pkg::DmcNdmReset]                = ndmreset_q;
    dmcontrol_rd[dm_pkg::DmcDmActive]                = dmactive_q;
    case (req_i.addr)
      dm_pkg::AddrDmControl: rdata = dmcontrol_rd;
      dm_pkg::AddrDmStatus:  rdata = dmstatus_i;
      dm_pkg::AddrHaltSum0:  rdata = haltsum0_i;
      // unimplemented registers read as zero
      default:               rdata = '0;
    endcase
  end

  // every accepted request gets one response, writes answer zero
  assign push_o      = accept;
  assign push_data_o = (req_i.op == dm_pkg::OpRead) ? rdata : '0;

endmodule

`default_nettype wire

// File: hdl/dm_pkg.sv
// --------------------
// debug module package
// shared widths, register map, DMI op codes and hart records
// --------------------
`default_nettype none

package dm_pkg;

  // --------------------
  // widths
  // --------------------
  typedef logic [6:0]  dmi_addr_t;
  typedef logic [31:0] dmi_word_t;
  typedef logic [9:0]  hartsel_t;

  // DMI operation, as carried in the request
  typedef enum logic [1:0] {
    OpNop   = 2'd0,
    OpRead  = 2'd1,
    OpWrite = 2'd2
  } dtm_op_e;

  // --------------------
  // register map
  // --------------------
  localparam dmi_addr_t AddrDmControl = 7'h10;
  localparam dmi_addr_t AddrDmStatus  = 7'h11;
  localparam dmi_addr_t AddrHaltSum0  = 7'h40;

  // debug spec 0.13
  localparam logic [3:0] DbgVersion = 4'd2;

  // dmcontrol bit positions
  localparam int unsigned DmcHaltReq      = 31;
  localparam int unsigned DmcResumeReq    = 30;
  localparam int unsigned DmcAckHaveReset = 28;
  localparam int unsigned DmcHartSelLo    = 16;
  localparam int unsigned DmcNdmReset     = 1;
  localparam int unsigned DmcDmActive     = 0;

  // --------------------
  // DMI port records
  // --------------------
  typedef struct packed {
    dmi_addr_t addr;
    dmi_word_t data;
    dtm_op_e   op;
  } dmi_req_t;

  // resp is the DTM status code, zero means success
  typedef struct packed {
    dmi_word_t   data;
    logic [1:0]  resp;
  } dmi_resp_t;

  // --------------------
  // hart side records
  // --------------------
  // broadcast to every hart slice
  typedef struct packed {
    hartsel_t hartsel;
    logic     dmactive;
    logic     ndmreset;
    logic     haltreq;
    logic     resume_set;
    logic     ack_havereset;
  } hart_ctrl_t;

  // what one slice reports back
  typedef struct packed {
    logic halted;
    logic running;
    logic unavail;
    logic havereset;
  } hart_stat_t;

endpackage

`default_nettype wire

// File: hdl/dm_status_merge.sv
// --------------------
// status merge
// builds dmstatus for the selected hart and the haltsum0 word
// --------------------
`timescale 1ns/1ps
`default_nettype none

module dm_status_merge #(
  parameter int unsigned NrHarts = 1
) (
  input  dm_pkg::hart_stat_t [NrHarts-1:0] stat_i,
  input  dm_pkg::hartsel_t                 hartsel_i,
  input  wire logic [NrHarts-1:0]          resumeack_i,
  input  wire logic [NrHarts-1:0]          halted_i,
  output dm_pkg::dmi_word_t                dmstatus_o,
  output dm_pkg::dmi_word_t                haltsum0_o
);
  dm_pkg::hart_stat_t sel_stat;
  logic               sel_resumeack;
  logic               exists;

  assign exists = (32'(hartsel_i) < NrHarts);

  // hart mux, a nonexistent hart leaves everything at zero
  always_comb begin : p_select
    sel_stat      = '0;
    sel_resumeack = 1'b0;
    for (int unsigned i = 0; i < NrHarts; i++) begin
      if (hartsel_i == dm_pkg::hartsel_t'(i)) begin
        sel_stat      = stat_i[i];
        sel_resumeack = resumeack_i[i];
      end
    end
  end

  // --------------------
  // dmstatus
  // --------------------
  // single hart selected, so any and all are the same
  always_comb begin : p_dmstatus
    dmstatus_o        = '0;
    dmstatus_o[3:0]   = dm_pkg::DbgVersion;
    // no authentication
    dmstatus_o[7]     = 1'b1;
    dmstatus_o[9:8]   = {2{sel_stat.halted}};
    dmstatus_o[11:10] = {2{sel_stat.running}};
    dmstatus_o[13:12] = {2{sel_stat.unavail}};
    dmstatus_o[15:14] = {2{~exists}};
    dmstatus_o[17:16] = {2{sel_resumeack}};
    dmstatus_o[19:18] = {2{sel_stat.havereset}};
  end

  // one bit per hart, upper bits zero
  assign haltsum0_o = dm_pkg::dmi_word_t'(halted_i);

endmodule

`default_nettype wire

// File: hdl/dm_top.sv
// --------------------
// debug module top
// DMI front end, hart slices, status merge and response queue
// --------------------
`timescale 1ns/1ps
`default_nettype none

module dm_top #(
  parameter int unsigned NrHarts   = 4,
  parameter int unsigned FifoDepth = 2
) (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               dmi_req_valid_i,
  input  dm_pkg::dmi_req_t        dmi_req_i,
  output logic                    dmi_req_ready_o,
  output logic                    dmi_resp_valid_o,
  output dm_pkg::dmi_resp_t       dmi_resp_o,
  input  wire logic               dmi_resp_ready_i,
  input  wire logic [NrHarts-1:0] halted_i,
  input  wire logic [NrHarts-1:0] unavailable_i,
  input  wire logic [NrHarts-1:0] resumeack_i,
  output logic [NrHarts-1:0]      haltreq_o,
  output logic [NrHarts-1:0]      resumereq_o,
  output logic                    clear_resumeack_o,
  output logic                    ndmreset_o,
  output logic                    dmactive_o
);
  dm_pkg::hart_ctrl_t                 hart_ctrl;
  dm_pkg::hart_stat_t [NrHarts-1:0]   hart_stat;
  logic [NrHarts-1:0]                 clear_ack;
  dm_pkg::dmi_word_t                  dmstatus;
  dm_pkg::dmi_word_t                  haltsum0;
  dm_pkg::dmi_word_t                  push_data;
  logic                               push;
  logic                               fifo_full;

  dm_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (dmi_req_valid_i),
    .req_i       (dmi_req_i),
    .fifo_full_i (fifo_full),
    .req_ready_o (dmi_req_ready_o),
    .push_o      (push),
    .push_data_o (push_data),
    .dmstatus_i  (dmstatus),
    .haltsum0_i  (haltsum0),
    .ctrl_o      (hart_ctrl),
    .dmactive_o  (dmactive_o),
    .ndmreset_o  (ndmreset_o)
  );

  for (genvar i = 0; i < NrHarts; i++) begin : g_hart
    hart_slice #(
      .HartIdx (i)
    ) u_slice (
      .clk_i             (clk_i),
      .rst_ni            (rst_ni),
      .ctrl_i            (hart_ctrl),
      .halted_i          (halted_i[i]),
      .unavailable_i     (unavailable_i[i]),
      .resumeack_i       (resumeack_i[i]),
      .haltreq_o         (haltreq_o[i]),
      .resumereq_o       (resumereq_o[i]),
      .clear_resumeack_o (clear_ack[i]),
      .stat_o            (hart_stat[i])
    );
  end

  // only the selected slice can pulse
  assign clear_resumeack_o = |clear_ack;

  dm_status_merge #(
    .NrHarts (NrHarts)
  ) u_merge (
    .stat_i      (hart_stat),
    .hartsel_i   (hart_ctrl.hartsel),
    .resumeack_i (resumeack_i),
    .halted_i    (halted_i),
    .dmstatus_o  (dmstatus),
    .haltsum0_o  (haltsum0)
  );

  dmi_resp_fifo #(
    .FifoDepth (FifoDepth)
  ) u_resp_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .push_data_i  (push_data),
    .full_o       (fifo_full),
    .resp_valid_o (dmi_resp_valid_o),
    .resp_o       (dmi_resp_o),
    .resp_ready_i (dmi_resp_ready_i)
  );

endmodule

`default_nettype wire

// File: hdl/dmi_resp_fifo.sv
// --------------------
// DMI response queue
// circular buffer holding read words until the debugger takes them
// --------------------
`timescale 1ns/1ps
`default_nettype none

module dmi_resp_fifo #(
  parameter int unsigned FifoDepth = 2
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              push_i,
  input  dm_pkg::dmi_word_t      push_data_i,
  output logic                   full_o,
  output logic                   resp_valid_o,
  output dm_pkg::dmi_resp_t      resp_o,
  input  wire logic              resp_ready_i
);
  localparam int unsigned PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  dm_pkg::dmi_word_t mem_q [FifoDepth];
  logic [PtrW-1:0]   wr_ptr_q;
  logic [PtrW-1:0]   rd_ptr_q;
  logic [CntW-1:0]   count_q;
  logic              pop;

  assign full_o       = (count_q == CntW'(FifoDepth));
  assign resp_valid_o = (count_q != '0);
  assign pop          = resp_valid_o & resp_ready_i;

  // every response reports success
  assign resp_o.data = mem_q[rd_ptr_q];
  assign resp_o.resp = 2'b00;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (push_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_mem
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/hart_slice.sv
// --------------------
// per-hart debug state
// halt/resume requests and havereset for one hart
// --------------------
`timescale 1ns/1ps
`default_nettype none

module hart_slice #(
  parameter int unsigned HartIdx = 0
) (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  dm_pkg::hart_ctrl_t   ctrl_i,
  input  wire logic            halted_i,
  input  wire logic            unavailable_i,
  input  wire logic            resumeack_i,
  output logic                 haltreq_o,
  output logic                 resumereq_o,
  output logic                 clear_resumeack_o,
  output dm_pkg::hart_stat_t   stat_o
);
  logic selected;
  logic haltreq_q;
  logic resume_q;
  logic clear_q;
  logic havereset_q;

  assign selected = (ctrl_i.hartsel == dm_pkg::hartsel_t'(HartIdx));

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      haltreq_q   <= 1'b0;
      resume_q    <= 1'b0;
      clear_q     <= 1'b0;
      havereset_q <= 1'b1;
    end else begin
      haltreq_q <= ctrl_i.haltreq & selected;
      clear_q   <= ctrl_i.resume_set & selected;
      // pending resume, old ack is ignored while it is being cleared
      if (!ctrl_i.dmactive) begin
        resume_q <= 1'b0;
      end else if (ctrl_i.resume_set && selected) begin
        resume_q <= 1'b1;
      end else if (resumeack_i && !clear_q) begin
        resume_q <= 1'b0;
      end
      // ndmreset wins over an acknowledge
      if (ctrl_i.ndmreset) begin
        havereset_q <= 1'b1;
      end else if (ctrl_i.ack_havereset && selected) begin
        havereset_q <= 1'b0;
      end
    end
  end

  assign haltreq_o         = haltreq_q;
  assign resumereq_o       = resume_q;
  assign clear_resumeack_o = clear_q;

  // halted and running exclude unavailable
  assign stat_o.halted    = halted_i & ~unavailable_i;
  assign stat_o.running   = ~halted_i & ~unavailable_i;
  assign stat_o.unavail   = unavailable_i;
  assign stat_o.havereset = havereset_q;

endmodule

`default_nettype wire

// File: testbench/dm_cases.txt
// op_addr_data_halted_unavail_resumeack_expdata_exphaltreq_expresumereq_expclear
// op 0 nop, 1 read, 2 write, plus 4 for back-to-back, F ends the list
1_10_00000000_0_0_0_00000000_0_0_0
1_11_00000000_0_0_0_000C0C82_0_0_0
2_10_80010002_0_0_0_00000000_0_0_0
2_10_80010003_0_0_0_00000000_0_0_0
1_10_00000000_0_0_0_00000001_0_0_0
2_10_D0020001_0_0_0_00000000_4_4_1
1_10_00000000_0_0_0_80020001_4_4_0
1_11_00000000_4_0_0_00000382_4_4_0
1_11_00000000_0_0_4_00030C82_4_0_0
1_40_00000000_A_0_0_0000000A_4_0_0
2_10_00030001_0_0_0_00000000_0_0_0
1_11_00000000_8_8_0_000C3082_0_0_0
1_11_00000000_8_0_0_000C0382_0_0_0
2_10_80040001_0_0_0_00000000_0_0_0
1_11_00000000_F_0_F_0000C082_0_0_0
2_10_00000003_0_0_0_00000000_0_0_0
2_10_10010001_0_0_0_00000000_0_0_0
1_11_00000000_0_0_0_00000C82_0_0_0
2_10_40020001_0_0_0_00000000_0_4_1
1_11_00000000_0_0_0_000C0C82_0_4_0
2_10_00000000_0_0_0_00000000_0_0_0
1_10_00000000_0_0_0_00000000_0_0_0
2_10_00000001_0_0_0_00000000_0_0_0
// back-to-back section, dropped addresses read zero
5_11_00000000_0_0_0_000C0C82_0_0_0
5_40_00000000_5_0_0_00000005_0_0_0
6_04_DEADBEEF_0_0_0_00000000_0_0_0
5_04_00000000_0_0_0_00000000_0_0_0
5_16_00000000_0_0_0_00000000_0_0_0
5_38_00000000_0_0_0_00000000_0_0_0
4_00_00000000_0_0_0_00000000_0_0_0
6_10_80010001_0_0_0_00000000_2_0_0
5_10_00000000_0_0_0_80010001_2_0_0
5_11_00000000_A_0_0_00000382_2_0_0
F_00_00000000_0_0_0_00000000_0_0_0

// File: testbench/tb_clkgen.sv
// --------------------
// testbench clock and reset generator
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_no
);
  initial begin : p_clk
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // release just after an edge, same offset as the stimulus
  initial begin : p_rst
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #2 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: testbench/tb_dm.sv
// --------------------
// debug module testbench
// replays DMI cases from a data file, checks responses and hart outputs
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_dm;
  localparam int unsigned NrHarts     = 4;
  localparam int unsigned MaxCases    = 64;
  localparam int unsigned CycleBudget = 200;
  localparam int unsigned ResetCycles = 16;
  localparam int          DriveDelay  = 2;

  logic                     clk;
  logic                     rst_n;
  logic                     dmi_req_valid;
  dm_pkg::dmi_req_t         dmi_req;
  logic                     dmi_req_ready;
  logic                     dmi_resp_valid;
  dm_pkg::dmi_resp_t        dmi_resp;
  logic                     dmi_resp_ready;
  logic [NrHarts-1:0]       halted;
  logic [NrHarts-1:0]       unavailable;
  logic [NrHarts-1:0]       resumeack;
  logic [NrHarts-1:0]       haltreq;
  logic [NrHarts-1:0]       resumereq;
  logic                     clear_resumeack;
  logic                     ndmreset;
  logic                     dmactive;

  // case word layout is described in the data file
  logic [99:0]              cases_mem [MaxCases];
  int unsigned              n_cases;
  logic                     cases_loaded;
  dm_pkg::dmi_word_t        exp_q [$];
  logic [15:0]              lfsr;
  logic                     dmactive_exp;
  logic                     ndmreset_exp;

  tb_clkgen #(
    .PeriodNs    (40),
    .ResetCycles (ResetCycles)
  ) u_clkgen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  dm_top #(
    .NrHarts   (NrHarts),
    .FifoDepth (2)
  ) dut_i (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .dmi_req_valid_i   (dmi_req_valid),
    .dmi_req_i         (dmi_req),
    .dmi_req_ready_o   (dmi_req_ready),
    .dmi_resp_valid_o  (dmi_resp_valid),
    .dmi_resp_o        (dmi_resp),
    .dmi_resp_ready_i  (dmi_resp_ready),
    .halted_i          (halted),
    .unavailable_i     (unavailable),
    .resumeack_i       (resumeack),
    .haltreq_o         (haltreq),
    .resumereq_o       (resumereq),
    .clear_resumeack_o (clear_resumeack),
    .ndmreset_o        (ndmreset),
    .dmactive_o        (dmactive)
  );

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic load_cases();
    int unsigned count;
    count = 0;
    $readmemh("testbench/dm_cases.txt", cases_mem);
    while (count < MaxCases && cases_mem[count][99:96] !== 4'hF) begin
      count++;
    end
    if (count == MaxCases) begin
      $display("case file has no end marker within %0d lines", MaxCases);
      $display("SOME TESTS FAILED");
      $fatal(1, "bad case file");
    end else begin
      n_cases      = count;
      cases_loaded = 1'b1;
    end
  endtask

  // --------------------
  // one DMI transaction
  // --------------------
  task automatic run_case(input int unsigned idx, input logic [99:0] c);
    logic [3:0] op_code;
    logic       burst;
    op_code       = c[99:96];
    burst         = op_code[2];
    halted        = c[55:52];
    unavailable   = c[51:48];
    resumeack     = c[47:44];
    dmi_req.addr  = c[94:88];
    dmi_req.data  = c[87:56];
    dmi_req.op    = dm_pkg::dtm_op_e'(op_code[1:0]);
    dmi_req_valid = 1'b1;
    // ready is stable from the falling edge on
    @(negedge clk);
    while (!dmi_req_ready) @(negedge clk);
    exp_q.push_back(c[43:12]);
    @(posedge clk);
    #(DriveDelay);
    dmi_req_valid = 1'b0;
    // an inactive module takes only dmactive from a dmcontrol write
    if (op_code[1:0] == dm_pkg::OpWrite && c[94:88] == dm_pkg::AddrDmControl) begin
      ndmreset_exp = dmactive_exp & c[56] & c[57];
      dmactive_exp = c[56];
    end
    check($sformatf("clear_resumeack_o (case %0d)", idx), 64'(clear_resumeack), 64'(c[3:0]));
    if (!burst) begin
      // the pulse is gone one cycle later
      @(posedge clk);
      #(DriveDelay);
      check($sformatf("clear_resumeack_o (case %0d)", idx), 64'(clear_resumeack), 64'(0));
    end
    check($sformatf("haltreq_o (case %0d)", idx), 64'(haltreq), 64'(c[11:8]));
    check($sformatf("resumereq_o (case %0d)", idx), 64'(resumereq), 64'(c[7:4]));
    check($sformatf("dmactive_o (case %0d)", idx), 64'(dmactive), 64'(dmactive_exp));
    check($sformatf("ndmreset_o (case %0d)", idx), 64'(ndmreset), 64'(ndmreset_exp));
  endtask

  // random response back-pressure
  initial begin : p_resp_ready
    lfsr           = 16'd18;
    dmi_resp_ready = 1'b0;
    forever begin
      @(posedge clk);
      #(DriveDelay);
      lfsr           = lfsr_next(lfsr);
      dmi_resp_ready = lfsr[0];
    end
  end

  // responses pop in request order
  initial begin : p_resp_check
    dm_pkg::dmi_word_t exp_word;
    forever begin
      @(negedge clk);
      if (rst_n && dmi_resp_valid && dmi_resp_ready) begin
        if (exp_q.size() == 0) begin
          $display("response at %0t with no request outstanding", $time);
          $display("SOME TESTS FAILED");
          $fatal(1, "unexpected response");
        end else begin
          exp_word = exp_q.pop_front();
          check("dmi_resp_o.data", 64'(dmi_resp.data), 64'(exp_word));
          check("dmi_resp_o.resp", 64'(dmi_resp.resp), 64'(0));
        end
      end
    end
  end

  initial begin : p_watchdog
    wait (cases_loaded);
    repeat (n_cases * CycleBudget + ResetCycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", n_cases * CycleBudget);
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin : p_main
    dmi_req_valid = 1'b0;
    dmi_req       = '0;
    halted        = '0;
    unavailable   = '0;
    resumeack     = '0;
    n_cases       = 0;
    cases_loaded  = 1'b0;
    dmactive_exp  = 1'b0;
    ndmreset_exp  = 1'b0;
    load_cases();
    wait (rst_n === 1'b1);
    @(posedge clk);
    #(DriveDelay);
    // --------------------
    // reset state
    // --------------------
    check("dmi_resp_valid_o", 64'(dmi_resp_valid), 64'(0));
    check("dmi_req_ready_o", 64'(dmi_req_ready), 64'(1));
    check("dmactive_o", 64'(dmactive), 64'(0));
    check("ndmreset_o", 64'(ndmreset), 64'(0));
    check("haltreq_o", 64'(haltreq), 64'(0));
    check("resumereq_o", 64'(resumereq), 64'(0));
    check("clear_resumeack_o", 64'(clear_resumeack), 64'(0));
    for (int unsigned i = 0; i < n_cases; i++) begin
      run_case(i, cases_mem[i]);
    end
    // let the checker drain what is queued
    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
    if (dmi_resp_valid) begin
      $display("response queue still holds data after the last expected response");
      $display("SOME TESTS FAILED");
      $fatal(1, "extra response");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
